//--- build.f
game_pkg.sv
player_row.sv
obstacle_field.sv
game_control.sv
max7219_driver.sv
game_top.sv
tb_game_top.sv

//--- game_control.sv
`timescale 1ns/1ps

module game_control (
	input  logic                  clock_50,
	input  logic                  rst_n,
	input  logic                  start,
	input  game_pkg::row_t        player,
	input  game_pkg::frame_t      field,
	output game_pkg::game_state_t state,
	output logic                  restart,
	output game_pkg::frame_t      frame,
	output logic                  lost
);
	import game_pkg::*;

	game_state_t state_next;
	logic        hit;
	frame_t      play_frame;

	// Wave reaching the player's row on top of the dot
	assign hit = |(field[0] & player);

	// ##################################################################
	// Game FSM
	// ##################################################################
	always_comb begin
		state_next = state;
		unique case (state)
			GAME_IDLE, GAME_LOST: begin
				if (start) begin
					state_next = GAME_PLAY;
				end
			end
			GAME_PLAY: begin
				// Field and player still hold old values during restart
				if (hit && !restart) begin
					state_next = GAME_LOST;
				end
			end
			default: state_next = GAME_IDLE;
		endcase
	end

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			state   <= GAME_IDLE;
			restart <= 1'b0;
		end else begin
			state   <= state_next;
			restart <= (state != GAME_PLAY) && (state_next == GAME_PLAY);
		end
	end

	assign lost = (state == GAME_LOST);

	// ##################################################################
	// Picture on the matrix
	// ##################################################################
	assign play_frame = field | frame_t'(player);

	always_comb begin
		unique case (state)
			GAME_PLAY: frame = play_frame;
			GAME_LOST: frame = LOSE_IMAGE;
			default:   frame = START_IMAGE;
		endcase
	end

	restart_in_play: assert property (
		@(posedge clock_50) disable iff (!rst_n)
		restart |-> (state == GAME_PLAY)
	);

endmodule

//--- game_pkg.sv
package game_pkg;

	// ##################################################################
	// Matrix geometry and timing
	// ##################################################################
	localparam int ROWS = 8;
	localparam int PRESCALER_W = 23;
	localparam int SPI_HALF = 4;
	localparam int WORD_BITS = 16;
	// Words sent once after reset, before the digit scan
	localparam int INIT_WORDS = 5;

	// Bit 7 is the leftmost LED of a row
	typedef logic [ROWS-1:0] row_t;
	// Index 0 is the bottom row where the player lives
	typedef row_t [ROWS-1:0] frame_t;

	typedef enum logic [1:0] {
		GAME_IDLE = 2'd0,
		GAME_PLAY = 2'd1,
		GAME_LOST = 2'd2
	} game_state_t;

	// MAX7219 register addresses
	typedef enum logic [3:0] {
		MAX_NOOP      = 4'h0,
		MAX_DIGIT0    = 4'h1,
		MAX_DIGIT1    = 4'h2,
		MAX_DIGIT2    = 4'h3,
		MAX_DIGIT3    = 4'h4,
		MAX_DIGIT4    = 4'h5,
		MAX_DIGIT5    = 4'h6,
		MAX_DIGIT6    = 4'h7,
		MAX_DIGIT7    = 4'h8,
		MAX_DECODE    = 4'h9,
		MAX_INTENSITY = 4'hA,
		MAX_SCANLIMIT = 4'hB,
		MAX_SHUTDOWN  = 4'hC,
		MAX_TEST      = 4'hF
	} max_reg_t;

	localparam logic [PRESCALER_W-1:0] FALL_PERIOD_DEFAULT = 23'd4_000_000;
	localparam logic [3:0] INTENSITY = 4'hA;

	localparam row_t WAVE_PATTERN = 8'b11100111;
	localparam row_t PLAYER_START = 8'b00010000;

	// ##################################################################
	// Fixed pictures, top row first
	// ##################################################################
	localparam frame_t START_IMAGE = {
		8'b01100110, 8'b10011001, 8'b10011001, 8'b01100110,
		8'b10000001, 8'b10100101, 8'b00011000, 8'b01111110
	};

	localparam frame_t LOSE_IMAGE = {
		8'b10011001, 8'b01100110, 8'b01100110, 8'b10011001,
		8'b00000000, 8'b00111100, 8'b01000010, 8'b01000010
	};

endpackage

//--- game_top.sv
`timescale 1ns/1ps

module game_top #(
	parameter logic [game_pkg::PRESCALER_W-1:0] fall_period = game_pkg::FALL_PERIOD_DEFAULT
) (
	input  logic clock_50,
	input  logic rst_n,
	input  logic start,
	input  logic left,
	input  logic right,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk,
	output logic lost
);
	import game_pkg::*;

	game_state_t state;
	logic        restart;
	row_t        player;
	frame_t      field;
	frame_t      frame;

	// ##################################################################
	// Game logic
	// ##################################################################
	player_row u_player_row (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.state    (state),
		.restart  (restart),
		.left     (left),
		.right    (right),
		.player   (player)
	);

	obstacle_field #(
		.fall_period(fall_period)
	) u_obstacle_field (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.state    (state),
		.restart  (restart),
		.field    (field)
	);

	game_control u_game_control (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.start    (start),
		.player   (player),
		.field    (field),
		.state    (state),
		.restart  (restart),
		.frame    (frame),
		.lost     (lost)
	);

	// ##################################################################
	// LED matrix
	// ##################################################################
	max7219_driver u_max7219_driver (
		.clock_50    (clock_50),
		.rst_n       (rst_n),
		.frame       (frame),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

endmodule

//--- max7219_driver.sv
`timescale 1ns/1ps

module max7219_driver (
	input  logic             clock_50,
	input  logic             rst_n,
	input  game_pkg::frame_t frame,
	output logic             max7219_din,
	output logic             max7219_ncs,
	output logic             max7219_clk
);
	import game_pkg::*;

	// One serial period per slot, slots 0 to 15 carry bits, the last is the gap
	logic [3:0]  period_cnt;
	logic [4:0]  slot;
	logic [3:0]  word_idx;
	logic [15:0] shift;
	logic        half_end;
	logic        period_end;
	logic [2:0]  digit;
	max_reg_t    word_addr;
	logic [7:0]  word_data;
	row_t        column;

	assign half_end   = (period_cnt == 4'(SPI_HALF - 1));
	assign period_end = (period_cnt == 4'(2 * SPI_HALF - 1));

	// ##################################################################
	// Word contents
	// ##################################################################
	assign digit = 3'(word_idx - 4'(INIT_WORDS));

	// Column k of the picture, bit r from row r
	always_comb begin
		for (int r = 0; r < ROWS; r++) begin
			column[r] = frame[r][ROWS - 1 - digit];
		end
	end

	always_comb begin
		unique case (word_idx)
			4'd0: begin
				word_addr = MAX_TEST;
				word_data = 8'h00;
			end
			4'd1: begin
				word_addr = MAX_DECODE;
				word_data = 8'h00;
			end
			4'd2: begin
				word_addr = MAX_SCANLIMIT;
				word_data = 8'h07;
			end
			4'd3: begin
				word_addr = MAX_INTENSITY;
				word_data = {4'h0, INTENSITY};
			end
			4'd4: begin
				word_addr = MAX_SHUTDOWN;
				word_data = 8'h01;
			end
			default: begin
				word_addr = max_reg_t'(MAX_DIGIT0 + {1'b0, digit});
				word_data = column;
			end
		endcase
	end

	// ##################################################################
	// Serial clock, chip select and shifter
	// ##################################################################
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			period_cnt  <= '0;
			slot        <= 5'(WORD_BITS);
			word_idx    <= '0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
		end else begin
			period_cnt <= period_end ? '0 : period_cnt + 1'b1;
			// Rising edge mid-slot, only inside a word
			if (half_end && !max7219_ncs) begin
				max7219_clk <= 1'b1;
			end
			if (period_end) begin
				max7219_clk <= 1'b0;
				if (slot == 5'(WORD_BITS)) begin
					slot        <= '0;
					max7219_ncs <= 1'b0;
				end else if (slot == 5'(WORD_BITS - 1)) begin
					slot        <= 5'(WORD_BITS);
					max7219_ncs <= 1'b1;
					// Init words once, then digits forever
					if (word_idx == 4'(INIT_WORDS + ROWS - 1)) begin
						word_idx <= 4'(INIT_WORDS);
					end else begin
						word_idx <= word_idx + 1'b1;
					end
				end else begin
					slot <= slot + 1'b1;
				end
			end
		end
	end

	// Loaded at the end of the gap, shifted on each falling edge
	always_ff @(posedge clock_50) begin
		if (period_end) begin
			if (slot == 5'(WORD_BITS)) begin
				shift <= {4'h0, word_addr, word_data};
			end else begin
				shift <= {shift[14:0], 1'b0};
			end
		end
	end

	assign max7219_din = !max7219_ncs && shift[15];

	ncs_holds_clk_low: assert property (
		@(posedge clock_50) disable iff (!rst_n)
		max7219_ncs |-> !max7219_clk
	);

endmodule

//--- obstacle_field.sv
`timescale 1ns/1ps

module obstacle_field #(
	parameter logic [game_pkg::PRESCALER_W-1:0] fall_period = game_pkg::FALL_PERIOD_DEFAULT
) (
	input  logic                  clock_50,
	input  logic                  rst_n,
	input  game_pkg::game_state_t state,
	input  logic                  restart,
	output game_pkg::frame_t      field
);
	import game_pkg::*;

	logic [PRESCALER_W-1:0] prescaler;
	logic                   fall_tick;
	frame_t                 shifted;
	frame_t                 wave_top;

	// ##################################################################
	// Fall prescaler
	// ##################################################################
	assign fall_tick = (state == GAME_PLAY) && (prescaler == fall_period - 1'b1);

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			prescaler <= '0;
		end else if (restart) begin
			prescaler <= '0;
		end else if (state == GAME_PLAY) begin
			if (fall_tick) begin
				prescaler <= '0;
			end else begin
				prescaler <= prescaler + 1'b1;
			end
		end
	end

	// ##################################################################
	// Falling rows
	// ##################################################################

	// Everything one row down, bottom row drops out
	assign shifted = field >> ROWS;

	// Wave alone in the top row
	assign wave_top = frame_t'(WAVE_PATTERN) << (ROWS * (ROWS - 1));

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			field <= '0;
		end else if (restart) begin
			field <= wave_top;
		end else if (fall_tick) begin
			// Empty field gets a fresh wave so play never stalls
			if (shifted == '0) begin
				field <= wave_top;
			end else begin
				field <= shifted;
			end
		end
	end

	// Once play has settled there is always something falling
	field_not_empty: assert property (
		@(posedge clock_50) disable iff (!rst_n)
		(state == GAME_PLAY && !restart) |-> (field != '0)
	);

	// Field holds still outside of play
	field_frozen: assert property (
		@(posedge clock_50) disable iff (!rst_n)
		(state != GAME_PLAY && $past(state) != GAME_PLAY) |-> $stable(field)
	);

endmodule

//--- player_row.sv
`timescale 1ns/1ps

module player_row (
	input  logic                  clock_50,
	input  logic                  rst_n,
	input  game_pkg::game_state_t state,
	input  logic                  restart,
	input  logic                  left,
	input  logic                  right,
	output game_pkg::row_t        player
);
	import game_pkg::*;

	row_t rot_left;
	row_t rot_right;

	// One step with wrap-around, bit 7 is the left edge
	assign rot_left  = {player[ROWS-2:0], player[ROWS-1]};
	assign rot_right = {player[0], player[ROWS-1:1]};

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			player <= PLAYER_START;
		end else if (restart) begin
			player <= PLAYER_START;
		end else if (state == GAME_PLAY) begin
			// Left wins if both strobes coincide
			if (left) begin
				player <= rot_left;
			end else if (right) begin
				player <= rot_right;
			end
		end
	end

	// ##################################################################
	// Checks
	// ##################################################################

	// Dot never splits or vanishes across any sequence of moves
	player_onehot: assert property (
		@(posedge clock_50) disable iff (!rst_n)
		$onehot(player)
	);

endmodule

//--- tb_game_top.sv
`timescale 1ns/1ps

module tb_game_top;
	import game_pkg::*;

	localparam int FALL = 3000;
	// Eight digit words plus alignment, with room to spare
	localparam int FRAME_GUARD = 1400;

	typedef enum int {
		ACT_WAIT,
		ACT_INIT,
		ACT_START,
		ACT_MOVES,
		ACT_PLACE,
		ACT_FRAME,
		ACT_LOST
	} action_t;

	logic clock_50 = 1'b0;
	logic rst_n;
	logic start;
	logic left;
	logic right;
	logic max7219_din;
	logic max7219_ncs;
	logic max7219_clk;
	logic lost;

	int cycle = 0;
	int limit = 0;
	int value_errors = 0;
	int protocol_errors = 0;

	// Step table
	action_t step_act[$];
	int      step_arg[$];
	int      step_wait[$];
	logic    step_exp[$];

	// Reference model of the game
	game_state_t m_state = GAME_IDLE;
	row_t        m_player = PLAYER_START;
	frame_t      m_field = '0;
	int          next_fall = 0;
	int          last_fall = -100000;

	// Serial decoder
	logic [15:0] rx_shift = '0;
	logic [15:0] rx_word = '0;
	int          rx_bits = 0;
	int          word_total = 0;
	logic [15:0] init_words [INIT_WORDS];
	event        word_done;

	game_top #(
		.fall_period(FALL)
	) UUT (
		.clock_50    (clock_50),
		.rst_n       (rst_n),
		.start       (start),
		.left        (left),
		.right       (right),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk),
		.lost        (lost)
	);

	always #4 clock_50 = ~clock_50;

	always @(posedge clock_50) begin
		cycle <= cycle + 1;
		if (limit != 0 && cycle >= limit) begin
			$display("Timeout, the run passed its limit of %0d cycles", limit);
			$display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ####################################################################
	// MAX7219 word decoder
	// ####################################################################
	always @(posedge max7219_clk) begin
		if (rst_n && !max7219_ncs) begin
			rx_shift = {rx_shift[14:0], max7219_din};
			rx_bits++;
		end
	end

	always @(posedge max7219_ncs) begin
		if (rst_n) begin
			if (rx_bits == 16) begin
				rx_word = rx_shift;
				if (word_total < INIT_WORDS) begin
					init_words[word_total] = rx_shift;
				end
				word_total++;
				-> word_done;
			end else if (rx_bits != 0) begin
				$display("Serial word at %0t had %0d clock pulses, not 16", $time, rx_bits);
				protocol_errors++;
			end
			rx_bits = 0;
		end
	end

	// ####################################################################
	// Reference model
	// ####################################################################
	function automatic frame_t expected_frame();
		frame_t f;
		case (m_state)
			GAME_PLAY: begin
				f = m_field;
				f[0] = m_field[0] | m_player;
			end
			GAME_LOST: f = LOSE_IMAGE;
			default:   f = START_IMAGE;
		endcase
		return f;
	endfunction

	task automatic check_collision();
		if (m_state == GAME_PLAY && (m_field[0] & m_player) != '0) begin
			m_state = GAME_LOST;
		end
	endtask

	task automatic apply_fall();
		for (int r = 0; r < ROWS - 1; r++) begin
			m_field[r] = m_field[r + 1];
		end
		m_field[ROWS - 1] = '0;
		if (m_field == '0) begin
			m_field[ROWS - 1] = WAVE_PATTERN;
		end
		check_collision();
	endtask

	task automatic advance(input int n);
		repeat (n) begin
			@(posedge clock_50);
			while (m_state == GAME_PLAY && cycle >= next_fall) begin
				apply_fall();
				last_fall = next_fall;
				next_fall = next_fall + FALL;
			end
		end
	endtask

	// Keep clear of the fall edge so the DUT has settled
	task automatic settle(input int guard);
		int target;
		if (m_state == GAME_PLAY && next_fall - cycle < guard) begin
			target = next_fall + 8;
			while (cycle < target) begin
				advance(1);
			end
		end
		while (cycle - last_fall < 8) begin
			advance(1);
		end
	endtask

	// ####################################################################
	// Stimulus
	// ####################################################################
	task automatic press_start();
		settle(16);
		@(posedge clock_50);
		start <= 1'b1;
		if (m_state != GAME_PLAY) begin
			m_state = GAME_PLAY;
			m_player = PLAYER_START;
			m_field = '0;
			m_field[ROWS - 1] = WAVE_PATTERN;
			// Strobe seen next edge, restart loads one edge later
			next_fall = cycle + 2 + FALL;
		end
		@(posedge clock_50);
		start <= 1'b0;
	endtask

	task automatic press_move(input logic to_left);
		settle(16);
		@(posedge clock_50);
		if (to_left) begin
			left <= 1'b1;
		end else begin
			right <= 1'b1;
		end
		if (m_state == GAME_PLAY) begin
			if (to_left) begin
				m_player = (m_player << 1) | (m_player >> (ROWS - 1));
			end else begin
				m_player = (m_player >> 1) | (m_player << (ROWS - 1));
			end
			check_collision();
		end
		@(posedge clock_50);
		left  <= 1'b0;
		right <= 1'b0;
	endtask

	task automatic place_player(input int position);
		row_t target;
		target = row_t'(1) << position;
		repeat (ROWS) begin
			if (m_player != target) begin
				press_move(1'b1);
			end
		end
	endtask

	// ####################################################################
	// Checks
	// ####################################################################
	task automatic capture_frame(output frame_t got, output logic [ROWS-1:0] seen);
		int k;
		got = '0;
		seen = '0;
		@(negedge max7219_ncs);
		repeat (ROWS) begin
			@(word_done);
			k = int'(rx_word[11:8]) - 1;
			if (rx_word[15:12] != 4'h0 || k < 0 || k >= ROWS) begin
				$display("Word %h at %0t is not a digit register write", rx_word, $time);
				protocol_errors++;
			end else begin
				seen[k] = 1'b1;
				// Column k is the leftmost bit minus k
				for (int r = 0; r < ROWS; r++) begin
					got[r][ROWS - 1 - k] = rx_word[r];
				end
			end
		end
	endtask

	task automatic check_frame();
		frame_t          exp_frame;
		frame_t          got;
		logic [ROWS-1:0] seen;
		settle(FRAME_GUARD);
		exp_frame = expected_frame();
		capture_frame(got, seen);
		assert (seen == '1) else begin
			$display("Only digits %b arrived in eight words at %0t", seen, $time);
			protocol_errors++;
		end
		assert (got == exp_frame) else begin
			$display("[FAIL] t=%0t frame: got %h, expected %h", $time, got, exp_frame);
			value_errors++;
		end
	endtask

	task automatic check_lost(input logic expected);
		settle(4);
		assert (lost === expected) else begin
			$display("[FAIL] t=%0t lost: got %b, expected %b", $time, lost, expected);
			value_errors++;
		end
	endtask

	task automatic check_init();
		logic [15:0] exp_word [INIT_WORDS];
		exp_word[0] = {4'h0, MAX_TEST, 8'h00};
		exp_word[1] = {4'h0, MAX_DECODE, 8'h00};
		exp_word[2] = {4'h0, MAX_SCANLIMIT, 8'h07};
		exp_word[3] = {4'h0, MAX_INTENSITY, 4'h0, INTENSITY};
		exp_word[4] = {4'h0, MAX_SHUTDOWN, 8'h01};
		wait (word_total >= INIT_WORDS);
		for (int i = 0; i < INIT_WORDS; i++) begin
			assert (init_words[i] == exp_word[i]) else begin
				$display("[FAIL] t=%0t init_word[%0d]: got %h, expected %h",
					$time, i, init_words[i], exp_word[i]);
				value_errors++;
			end
		end
	endtask

	task automatic add_step(input action_t act, input int arg, input int waits,
		input logic expected);
		step_act.push_back(act);
		step_arg.push_back(arg);
		step_wait.push_back(waits);
		step_exp.push_back(expected);
	endtask

	task automatic build_table();
		add_step(ACT_INIT, 0, 0, 1'b0);
		add_step(ACT_LOST, 0, 0, 1'b0);
		add_step(ACT_FRAME, 0, 0, 1'b0);
		// Start, then random moves
		add_step(ACT_START, 0, 10, 1'b0);
		add_step(ACT_FRAME, 0, 0, 1'b0);
		add_step(ACT_MOVES, 6, 10, 1'b0);
		add_step(ACT_FRAME, 0, 0, 1'b0);
		add_step(ACT_MOVES, 5, 10, 1'b0);
		add_step(ACT_FRAME, 0, 0, 1'b0);
		// Wave walks down
		add_step(ACT_WAIT, 0, FALL, 1'b0);
		add_step(ACT_FRAME, 0, 0, 1'b0);
		add_step(ACT_WAIT, 0, FALL, 1'b0);
		add_step(ACT_FRAME, 0, 0, 1'b0);
		add_step(ACT_WAIT, 0, FALL, 1'b0);
		add_step(ACT_FRAME, 0, 0, 1'b0);
		// Player under the gap as the wave lands, then the reload
		add_step(ACT_PLACE, 3, FALL + 2000, 1'b0);
		add_step(ACT_LOST, 0, 0, 1'b0);
		add_step(ACT_FRAME, 0, 2000, 1'b0);
		add_step(ACT_FRAME, 0, 0, 1'b0);
		// Player under a lit bit
		add_step(ACT_PLACE, 6, 7 * FALL, 1'b0);
		add_step(ACT_LOST, 0, 0, 1'b1);
		add_step(ACT_FRAME, 0, 0, 1'b0);
		// Restart from lost
		add_step(ACT_START, 0, 10, 1'b0);
		add_step(ACT_LOST, 0, 0, 1'b0);
		add_step(ACT_FRAME, 0, 0, 1'b0);
	endtask

	initial begin
		int wait_sum;
		rst_n = 1'b0;
		start = 1'b0;
		left  = 1'b0;
		right = 1'b0;
		void'($urandom(83096));
		build_table();
		wait_sum = 0;
		foreach (step_wait[i]) begin
			wait_sum += step_wait[i];
		end
		limit = wait_sum + 3000 * step_act.size();

		repeat (16) @(posedge clock_50);
		rst_n <= 1'b1;

		for (int i = 0; i < step_act.size(); i++) begin
			case (step_act[i])
				ACT_INIT:  check_init();
				ACT_START: press_start();
				ACT_MOVES: begin
					repeat (step_arg[i]) press_move(1'($urandom % 2));
				end
				ACT_PLACE: place_player(step_arg[i]);
				ACT_FRAME: check_frame();
				ACT_LOST:  check_lost(step_exp[i]);
				default:   ;
			endcase
			advance(step_wait[i]);
		end

		$display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
